/* source/osCheckerPkg.sv */
`default_nettype none

package osCheckerPkg;

    localparam int symbolWidth = 8;
    localparam int orderedSetWidth = 128; // 16 symbols

    // 8b/10b control and data codes
    localparam logic [symbolWidth-1:0] comSymbol = 8'hBC; // K28.5
    localparam logic [symbolWidth-1:0] padSymbol = 8'hF7; // K23.7
    localparam logic [symbolWidth-1:0] ts1Id = 8'h4A;
    localparam logic [symbolWidth-1:0] ts2Id = 8'h45;

    // symbol indices inside a training set
    localparam int linkSymbolPos = 1;
    localparam int laneSymbolPos = 2;
    localparam int rateSymbolPos = 4;
    localparam int controlSymbolPos = 5;
    localparam int idSymbolPos = 10;

    localparam int speedChangeBit = 7; // of the rate symbol
    localparam int upconfigureBit = 2; // of the control symbol

    localparam int substateWidth = 5;

    // training machine substates, only the ones with a rule here
    localparam logic [substateWidth-1:0] pollingActive = 5'd2;
    localparam logic [substateWidth-1:0] pollingConfiguration = 5'd3;
    localparam logic [substateWidth-1:0] configurationLinkWidthStart = 5'd4;
    localparam logic [substateWidth-1:0] configurationLanenumWait = 5'd6;
    localparam logic [substateWidth-1:0] configurationLanenumAccept = 5'd7;
    localparam logic [substateWidth-1:0] configurationComplete = 5'd8;
    localparam logic [substateWidth-1:0] recoveryRcvrLock = 5'd11;

    typedef enum logic [1:0]
    {
        osNone = 2'd0,
        osTs1 = 2'd1,
        osTs2 = 2'd2
    } osKind_t;

endpackage

`default_nettype wire

/* source/osDecoder.sv */
`default_nettype none

module osDecoder
    import osCheckerPkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [orderedSetWidth-1:0] orderedSet,
    input  wire logic                       valid,
    output logic                            decValid,
    output osKind_t                         kind,
    output logic [symbolWidth-1:0]          linkField,
    output logic [symbolWidth-1:0]          laneField,
    output logic [symbolWidth-1:0]          rateField,
    output logic                            upconfigureField
);

    logic [symbolWidth-1:0] startSymbol;
    logic [symbolWidth-1:0] idSymbol;
    logic [symbolWidth-1:0] controlSymbol;
    osKind_t                kindNext;

    assign startSymbol = orderedSet[0 +: symbolWidth];
    assign idSymbol = orderedSet[idSymbolPos*symbolWidth +: symbolWidth];
    assign controlSymbol = orderedSet[controlSymbolPos*symbolWidth +: symbolWidth];

    // only a COM-led set with a known identifier is a training set
    always_comb
    begin
        kindNext = osNone;
        if (startSymbol == comSymbol)
        begin
            if (idSymbol == ts1Id)
                kindNext = osTs1;
            else if (idSymbol == ts2Id)
                kindNext = osTs2;
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            decValid <= 1'b0;
            kind <= osNone;
        end
        else
        begin
            decValid <= valid;
            if (valid)
                kind <= kindNext;
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid)
        begin
            linkField <= orderedSet[linkSymbolPos*symbolWidth +: symbolWidth];
            laneField <= orderedSet[laneSymbolPos*symbolWidth +: symbolWidth];
            rateField <= orderedSet[rateSymbolPos*symbolWidth +: symbolWidth];
            upconfigureField <= controlSymbol[upconfigureBit];
        end
    end

endmodule

`default_nettype wire

/* source/osHistory.sv */
`default_nettype none

module osHistory
    import osCheckerPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   decValid,
    input  wire logic [symbolWidth-1:0] linkField,
    input  wire logic [symbolWidth-1:0] rateField,
    input  wire logic                   upconfigureField,
    output logic                        changed,
    output logic [symbolWidth-1:0]      linkNumberOut,
    output logic [symbolWidth-1:0]      rateId,
    output logic                        upconfigureCapability
);

    logic rateDiffers;
    logic upconfigureDiffers;

    // compared against the set before this one
    assign rateDiffers = rateField != rateId;
    assign upconfigureDiffers = upconfigureField != upconfigureCapability;
    assign changed = decValid && (rateDiffers || upconfigureDiffers);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            linkNumberOut <= '0;
            rateId <= '0;
            upconfigureCapability <= 1'b0;
        end
        else if (decValid)
        begin
            linkNumberOut <= linkField;
            rateId <= rateField;
            upconfigureCapability <= upconfigureField;
        end
    end

endmodule

`default_nettype wire

/* source/osMatcher.sv */
`default_nettype none

module osMatcher
    import osCheckerPkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [substateWidth-1:0] substate,
    input  wire logic [symbolWidth-1:0]   linkNumber,
    input  wire logic [symbolWidth-1:0]   laneNumber,
    input  wire logic                     directedSpeedChange,
    input  wire logic                     decValid,
    input  wire osKind_t                  kind,
    input  wire logic [symbolWidth-1:0]   linkField,
    input  wire logic [symbolWidth-1:0]   laneField,
    input  wire logic [symbolWidth-1:0]   rateField,
    input  wire logic                     changed,
    output logic                          countUp,
    output logic                          resetCounter
);

    logic                     counting;     // phase, low means seeking
    logic [substateWidth-1:0] lastSubstate;
    logic                     countingNow;
    logic                     countingNext;

    logic isTs1;
    logic isTs2;
    logic linkPad;
    logic lanePad;
    logic linkMatch;
    logic laneMatch;
    logic speedMatch;
    logic ruleMatch;

    assign isTs1 = kind == osTs1;
    assign isTs2 = kind == osTs2;
    assign linkPad = linkField == padSymbol;
    assign lanePad = laneField == padSymbol;
    assign linkMatch = linkField == linkNumber;
    assign laneMatch = laneField == laneNumber;
    assign speedMatch = rateField[speedChangeBit] == directedSpeedChange;

    // a new substate always starts from seeking
    assign countingNow = counting && (substate == lastSubstate);

    always_comb
    begin
        case (substate)
            pollingActive:
            begin
                ruleMatch = isTs1 && linkPad && lanePad;
            end
            pollingConfiguration:
            begin
                ruleMatch = isTs2 && linkPad && lanePad;
            end
            configurationLinkWidthStart:
            begin
                ruleMatch = isTs1 && linkMatch && lanePad;
            end
            configurationLanenumWait, configurationLanenumAccept:
            begin
                ruleMatch = isTs1 && linkMatch && laneMatch;
            end
            configurationComplete:
            begin
                // rate or upconfigure change mid-run restarts it
                ruleMatch = isTs2 && linkMatch && laneMatch && !(countingNow && changed);
            end
            recoveryRcvrLock:
            begin
                ruleMatch = (isTs1 || isTs2) && linkMatch && laneMatch && speedMatch;
            end
            default:
            begin
                ruleMatch = 1'b0; // no rule for this substate
            end
        endcase
    end

    assign countUp = decValid && ruleMatch;

    // a set decides the phase, otherwise it holds
    always_comb
    begin
        if (decValid)
            countingNext = ruleMatch;
        else
            countingNext = countingNow;
    end

    // high while counting or on a first match, low on a breaking set
    assign resetCounter = countingNext;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            counting <= 1'b0;
            lastSubstate <= '0;
        end
        else
        begin
            counting <= countingNext;
            lastSubstate <= substate;
        end
    end

endmodule

`default_nettype wire

/* source/osChecker.sv */
`default_nettype none

module osChecker
    import osCheckerPkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [orderedSetWidth-1:0] orderedSet,
    input  wire logic                       valid,
    input  wire logic [substateWidth-1:0]   substate,
    input  wire logic [symbolWidth-1:0]     linkNumber,
    input  wire logic [symbolWidth-1:0]     laneNumber,
    input  wire logic                       directedSpeedChange,
    output logic                            countUp,
    output logic                            resetCounter,
    output logic [symbolWidth-1:0]          rateId,
    output logic [symbolWidth-1:0]          linkNumberOut,
    output logic                            upconfigureCapability
);

    logic                   decValid;
    osKind_t                kind;
    logic [symbolWidth-1:0] linkField;
    logic [symbolWidth-1:0] laneField;
    logic [symbolWidth-1:0] rateField;
    logic                   upconfigureField;
    logic                   changed;

    osDecoder decoder (
        .clk              (clk),
        .reset            (reset),
        .orderedSet       (orderedSet),
        .valid            (valid),
        .decValid         (decValid),
        .kind             (kind),
        .linkField        (linkField),
        .laneField        (laneField),
        .rateField        (rateField),
        .upconfigureField (upconfigureField)
    );

    osHistory history (
        .clk                   (clk),
        .reset                 (reset),
        .decValid              (decValid),
        .linkField             (linkField),
        .rateField             (rateField),
        .upconfigureField      (upconfigureField),
        .changed               (changed),
        .linkNumberOut         (linkNumberOut),
        .rateId                (rateId),
        .upconfigureCapability (upconfigureCapability)
    );

    osMatcher matcher (
        .clk                 (clk),
        .reset               (reset),
        .substate            (substate),
        .linkNumber          (linkNumber),
        .laneNumber          (laneNumber),
        .directedSpeedChange (directedSpeedChange),
        .decValid            (decValid),
        .kind                (kind),
        .linkField           (linkField),
        .laneField           (laneField),
        .rateField           (rateField),
        .changed             (changed),
        .countUp             (countUp),
        .resetCounter        (resetCounter)
    );

endmodule

`default_nettype wire

/* sim/osCheckerMonitor.sv */
`default_nettype none

module osCheckerMonitor
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       countUp,
    input  wire logic       resetCounter,
    input  wire logic [7:0] rateId,
    input  wire logic [7:0] linkNumberOut,
    input  wire logic       upconfigureCapability,
    input  wire logic       checkEnable,
    input  wire logic       expCountUp,
    input  wire logic       expResetCounter,
    input  wire logic [7:0] expRate,
    input  wire logic [7:0] expLink,
    input  wire logic       expUpcfg,
    output int              errorCount
);
    timeunit 1ns;
    timeprecision 1ps;

    initial errorCount = 0;

    // sampled on the rising edge, before the DUT registers move
    always @(posedge clk)
    begin
        if (reset && checkEnable)
        begin
            if (countUp !== expCountUp)
            begin
                $display("error at %0t: countUp is %b, expected %b", $time, countUp, expCountUp);
                errorCount++;
            end
            if (resetCounter !== expResetCounter)
            begin
                $display("error at %0t: resetCounter is %b, expected %b",
                         $time, resetCounter, expResetCounter);
                errorCount++;
            end
            if (rateId !== expRate || linkNumberOut !== expLink)
            begin
                $display("error at %0t: rateId/linkNumberOut are %h/%h, expected %h/%h",
                         $time, rateId, linkNumberOut, expRate, expLink);
                errorCount++;
            end
            if (upconfigureCapability !== expUpcfg)
            begin
                $display("error at %0t: upconfigureCapability is %b, expected %b",
                         $time, upconfigureCapability, expUpcfg);
                errorCount++;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/osChecker_checker.sv */
`default_nettype none

module osCheckerChecker
(
    input wire logic clk,
    input wire logic reset,
    input wire logic valid,
    input wire logic decValid,
    input wire logic countUp,
    input wire logic resetCounter
);
    timeunit 1ns;
    timeprecision 1ps;

    // back to back counts need back to back sets
    assert property (@(posedge clk) disable iff (!reset)
        countUp && $past(countUp) |-> $past(valid) && $past(valid, 2) && decValid)
        else $error("countUp high twice without consecutive sets");

    assert property (@(posedge clk) disable iff (!reset) countUp |-> resetCounter)
        else $error("countUp without resetCounter");

    assert property (@(posedge clk) disable iff (!reset) countUp |-> $past(valid))
        else $error("countUp not preceded by valid");

endmodule

bind osChecker osCheckerChecker assertions (.clk(clk), .reset(reset), .valid(valid),
    .decValid(decValid), .countUp(countUp), .resetCounter(resetCounter));

`default_nettype wire

/* sim/osCheckerTb.sv */
`default_nettype none

module osCheckerTb
    import osCheckerPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [substateWidth-1:0] sub;
        logic [7:0] start, link, lane, id, rate, ctrl;
        logic dsc, valid, cu, rc;
    } tableRow_t;

    localparam logic [7:0] myLink = 8'h05;
    localparam logic [7:0] myLane = 8'h03;
    localparam logic [7:0] badStart = 8'h3C;
    localparam int edgeTimeout = 100;

    logic clk, reset, valid, directedSpeedChange;
    logic [orderedSetWidth-1:0] orderedSet;
    logic [substateWidth-1:0] substate, groupSubstate;
    logic countUp, resetCounter, upconfigureCapability;
    logic [7:0] rateId, linkNumberOut;
    logic checkEnable, expCountUp, expResetCounter, expUpcfg;
    logic [7:0] expRate, expLink;
    logic [15:0] lfsr;
    logic timedOut;
    int errorCount;
    tableRow_t rows[$];

    osChecker uut (.clk(clk), .reset(reset), .orderedSet(orderedSet), .valid(valid),
        .substate(substate), .linkNumber(myLink), .laneNumber(myLane),
        .directedSpeedChange(directedSpeedChange), .countUp(countUp),
        .resetCounter(resetCounter), .rateId(rateId), .linkNumberOut(linkNumberOut),
        .upconfigureCapability(upconfigureCapability));

    osCheckerMonitor monitor (.clk(clk), .reset(reset), .countUp(countUp),
        .resetCounter(resetCounter), .rateId(rateId), .linkNumberOut(linkNumberOut),
        .upconfigureCapability(upconfigureCapability), .checkEnable(checkEnable),
        .expCountUp(expCountUp), .expResetCounter(expResetCounter), .expRate(expRate),
        .expLink(expLink), .expUpcfg(expUpcfg), .errorCount(errorCount));

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [7:0] randomByte();
        logic [7:0] value;
        value = '0;
        for (int b = 0; b < 8; b++)
        begin
            value = {value[6:0], lfsr[15]};
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
        return value;
    endfunction

    function automatic logic [orderedSetWidth-1:0] buildSet(tableRow_t r);
        logic [orderedSetWidth-1:0] set;
        for (int s = 0; s < 16; s++)
            set[s*8 +: 8] = randomByte(); // filler for unused symbols
        set[0 +: 8] = r.start;
        set[linkSymbolPos*8 +: 8] = r.link;
        set[laneSymbolPos*8 +: 8] = r.lane;
        set[rateSymbolPos*8 +: 8] = r.rate;
        set[controlSymbolPos*8 +: 8] = r.ctrl;
        set[idSymbolPos*8 +: 8] = r.id;
        return set;
    endfunction

    task automatic addRow(input logic [7:0] start, link, lane, id, rate, ctrl,
                          input logic dsc, v, cu, rc);
        tableRow_t r;
        r.sub = groupSubstate;
        r.start = start;
        r.link = link;
        r.lane = lane;
        r.id = id;
        r.rate = rate;
        r.ctrl = ctrl;
        r.dsc = dsc;
        r.valid = v;
        r.cu = cu;
        r.rc = rc;
        rows.push_back(r);
    endtask

    task automatic idleRow(input logic dsc);
        addRow(comSymbol, padSymbol, padSymbol, ts1Id, 8'h00, 8'h00, dsc, 0, 0, 0);
    endtask

    task automatic waitFalling();
        int t;
        t = 0;
        while (clk !== 1'b1 && t < edgeTimeout)
        begin
            #1;
            t++;
        end
        while (clk !== 1'b0 && t < edgeTimeout)
        begin
            #1;
            t++;
        end
        if (t >= edgeTimeout)
        begin
            timedOut = 1'b1;
            $display("timed out waiting for a falling clock edge at %0t", $time);
        end
    endtask

    task automatic buildTable();
        groupSubstate = pollingActive;
        idleRow(0);
        addRow(comSymbol, padSymbol, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, padSymbol, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, padSymbol, padSymbol, ts2Id, 8'h02, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, padSymbol, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        idleRow(0); // next substate drops resetCounter
        groupSubstate = pollingConfiguration;
        addRow(comSymbol, padSymbol, padSymbol, ts2Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, padSymbol, padSymbol, ts2Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, padSymbol, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, padSymbol, padSymbol, ts2Id, 8'h02, 8'h00, 0, 1, 1, 1);
        idleRow(0);
        groupSubstate = configurationLinkWidthStart;
        addRow(comSymbol, myLink, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, myLink, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, 8'h06, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, myLink, padSymbol, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        idleRow(0);
        groupSubstate = configurationLanenumWait;
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, myLink, 8'h04, ts1Id, 8'h02, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(badStart, myLink, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        idleRow(0);
        groupSubstate = configurationLanenumAccept;
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, 8'h09, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h02, 8'h00, 0, 1, 1, 1);
        idleRow(0);
        groupSubstate = configurationComplete;
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h02, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h06, 8'h00, 0, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h06, 8'h00, 0, 1, 1, 1);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h06, 8'h04, 0, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h06, 8'h04, 0, 1, 1, 1);
        idleRow(0);
        groupSubstate = recoveryRcvrLock;
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h86, 8'h04, 1, 1, 1, 1);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h86, 8'h04, 1, 1, 1, 1);
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h06, 8'h04, 1, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h86, 8'h04, 1, 1, 1, 1);
        // a gap without a set holds the run
        addRow(comSymbol, padSymbol, padSymbol, ts1Id, 8'h00, 8'h00, 1, 0, 0, 1);
        addRow(comSymbol, myLink, myLane, ts2Id, 8'h06, 8'h04, 0, 1, 1, 1);
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h86, 8'h04, 0, 1, 0, 0);
        addRow(comSymbol, myLink, myLane, ts1Id, 8'h06, 8'h04, 0, 1, 1, 1);
        idleRow(0);
        groupSubstate = '0; // tail rows select no rule
        idleRow(0);
        idleRow(0);
    endtask

    initial
    begin
        reset = 1'b0;
        valid = 1'b0;
        orderedSet = '0;
        substate = '0;
        directedSpeedChange = 1'b0;
        checkEnable = 1'b0;
        expCountUp = 1'b0;
        expResetCounter = 1'b0;
        expRate = '0;
        expLink = '0;
        expUpcfg = 1'b0;
        lfsr = 16'd23770;
        timedOut = 1'b0;
        groupSubstate = '0;
        buildTable();
        for (int c = 0; c < 4 && !timedOut; c++)
            waitFalling();
        reset = 1'b1;
        for (int i = 0; i < rows.size() && !timedOut; i++)
        begin
            waitFalling();
            substate = rows[i].sub;
            directedSpeedChange = rows[i].dsc;
            valid = rows[i].valid;
            orderedSet = buildSet(rows[i]);
            checkEnable = 1'b1;
            if (i > 0)
            begin
                expCountUp = rows[i-1].cu; // checked one cycle late
                expResetCounter = rows[i-1].rc;
            end
            if (i > 1 && rows[i-2].valid)
            begin
                expRate = rows[i-2].rate;
                expLink = rows[i-2].link;
                expUpcfg = rows[i-2].ctrl[upconfigureBit];
            end
        end
        waitFalling();
        $display("rows applied: %0d, errors: %0d", rows.size(), errorCount);
        if (errorCount == 0 && !timedOut)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* osChecker.f */
source/osCheckerPkg.sv
source/osDecoder.sv
source/osHistory.sv
source/osMatcher.sv
source/osChecker.sv
sim/osCheckerMonitor.sv
sim/osChecker_checker.sv
sim/osCheckerTb.sv

/* runSim.sh */
#!/bin/sh
# build and run with Verilator, then look for the fail message in the log
verilator --binary --timing --assert -f osChecker.f --top-module osCheckerTb \
    -o osCheckerSim > build.log 2>&1 \
    && ./obj_dir/osCheckerSim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "ERRORS FOUND" sim.log \
    && { echo "simulation reported errors"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
